// File: colmix_pkg.sv
// shared types and constants for the colour mixer, imported by every design module
package colmix_pkg;

    // three background planes plus the object plane
    localparam int num_layers = 4;

    // bit 7 is the priority bit, bits 3..0 the colour bits
    typedef logic [7:0] pixel_t;

    // red in the top byte, then green, then blue
    typedef logic [23:0] rgb_t;

    // host address map, one region per 1k block
    typedef enum logic [1:0] {
        palette_gr = 2'd0,
        palette_b  = 2'd1,
        prom       = 2'd2,
        regs       = 2'd3
    } region_e;

    // what a layer stage hands to the mixer
    typedef struct packed {
        pixel_t pxl;
        logic   opaque;
    } layer_out_t;

    // per-layer config register
    typedef struct packed {
        logic       en;
        logic [3:0] mask;
    } layer_cfg_t;

endpackage

// File: colmix_ifs.sv
// memory-access bus from the host bridge to the mixer's PROM and palette
interface mem_if import colmix_pkg::*; ();

    // single-cycle access strobe
    logic        stb;
    region_e     region;
    logic        we;
    // word address inside the region
    logic [9:0]  addr;
    logic [15:0] wdata;
    // valid on the cycle after stb
    logic [15:0] rdata;

    modport manager (
        output stb, region, we, addr, wdata,
        input  rdata
    );

    modport subordinate (
        input  stb, region, we, addr, wdata,
        output rdata
    );

endinterface

// File: palette_ram.sv
// dual-port 1024 entry palette, host port for load and read-back, video port for colour lookup
module palette_ram import colmix_pkg::*; (
    input  logic        clk,
    input  logic [9:0]  host_addr,
    input  logic        host_we_gr,
    input  logic        host_we_b,
    input  logic [15:0] host_wdata,
    output logic [15:0] host_rdata_gr,
    output logic [7:0]  host_rdata_b,
    input  logic [9:0]  vid_addr,
    input  logic        vid_en,
    output rgb_t        vid_rgb
);

    // green in the high byte, red in the low byte
    logic [15:0] gr_mem [1024];
    logic [7:0]  b_mem  [1024];

    // host side, read before write
    always_ff @(posedge clk) begin
        if (host_we_gr)
            gr_mem[host_addr] <= host_wdata;
        if (host_we_b)
            b_mem[host_addr] <= host_wdata[7:0];
        host_rdata_gr <= gr_mem[host_addr];
        host_rdata_b  <= b_mem[host_addr];
    end

    // video side, reorder to red, green, blue
    always_ff @(posedge clk) begin
        if (vid_en)
            vid_rgb <= {gr_mem[vid_addr][7:0], gr_mem[vid_addr][15:8], b_mem[vid_addr]};
    end

endmodule

// File: layer_unit.sv
// one layer stage, registers the pixel and decides opacity under its config
module layer_unit import colmix_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       pxl_cen,
    input  pixel_t     pxl,
    input  layer_cfg_t cfg,
    output layer_out_t out
);

    logic opaque_nxt;

    // opaque when enabled and some unmasked colour bit is set
    assign opaque_nxt = cfg.en && |(pxl[3:0] & cfg.mask);

    // opaque flag feeds the mixer's PROM address
    always_ff @(posedge clk) begin
        if (reset)
            out.opaque <= 1'b0;
        else if (pxl_cen)
            out.opaque <= opaque_nxt;
    end

    // disabled layer passes a zero pixel
    always_ff @(posedge clk) begin
        if (pxl_cen)
            out.pxl <= cfg.en ? pxl : '0;
    end

endmodule

// File: host_bridge.sv
// four-phase host port, decodes addresses, keeps layer config and priority select registers
module host_bridge import colmix_pkg::*; #(
    parameter int host_addr_w = 12
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   req,
    input  logic                   we,
    input  logic [host_addr_w-1:0] addr,
    input  logic [15:0]            wdata,
    output logic                   ack,
    output logic [15:0]            rdata,
    output layer_cfg_t             layer_cfg [num_layers],
    output logic [1:0]             prisel,
    mem_if.manager                 mem
);

    localparam int idx_w = $clog2(num_layers);
    localparam logic [host_addr_w-1:0] regs_base = host_addr_w'('hC00);
    localparam logic [host_addr_w-1:0] prisel_addr = host_addr_w'('hC00 + num_layers);

    typedef enum logic [1:0] {st_idle, st_access, st_respond, st_release} state_e;

    state_e      state;
    region_e     region;
    logic        is_cfg;
    logic        is_prisel;
    logic [15:0] local_rdata;

    // anything at or above the register block counts as regs
    always_comb begin
        if (addr >= regs_base)
            region = regs;
        else
            region = region_e'(addr[11:10]);
    end

    assign is_cfg    = (addr >= regs_base) && (addr < prisel_addr);
    assign is_prisel = (addr == prisel_addr);

    // host holds addr and data stable while req is up
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:    if (req) state <= st_access;
                st_access:  state <= st_respond;
                st_respond: state <= st_release;
                st_release: if (!req) state <= st_idle;
                default:    state <= st_idle;
            endcase
        end
    end

    // local registers written in the access cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            layer_cfg <= '{default: '0};
            prisel    <= '0;
        end else if (state == st_access && we) begin
            if (is_cfg)
                layer_cfg[addr[idx_w-1:0]] <= layer_cfg_t'(wdata[$bits(layer_cfg_t)-1:0]);
            if (is_prisel)
                prisel <= wdata[1:0];
        end
    end

    // zero-extended read of local registers
    always_comb begin
        local_rdata = '0;
        if (is_cfg)
            local_rdata[$bits(layer_cfg_t)-1:0] = layer_cfg[addr[idx_w-1:0]];
        else if (is_prisel)
            local_rdata[1:0] = prisel;
    end

    // mixer answer is on the bus during respond
    always_ff @(posedge clk) begin
        if (state == st_respond)
            rdata <= (region == regs) ? local_rdata : mem.rdata;
    end

    // register block never goes out on the bus
    assign mem.stb    = (state == st_access) && (region != regs);
    assign mem.region = region;
    assign mem.we     = we;
    assign mem.addr   = addr[9:0];
    assign mem.wdata  = wdata;

    assign ack = (state == st_release);

    // ack only answers a pending request
    ack_after_req: assert property (@(posedge clk) disable iff (reset)
        $rose(ack) |-> $past(req));

    // ack holds until the host lets go
    ack_falls_late: assert property (@(posedge clk) disable iff (reset)
        $fell(ack) |-> !$past(req));

endmodule

// File: priority_mixer.sv
// picks the winning layer through the priority PROM and looks up its colour in the palette
module priority_mixer import colmix_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       pxl_cen,
    input  layer_out_t layers [num_layers],
    input  logic [1:0] prisel,
    input  logic       lhbl,
    input  logic       lvbl,
    output rgb_t       rgb,
    output logic       lhbl_dly,
    output logic       lvbl_dly,
    mem_if.subordinate mem
);

    localparam int win_w   = $clog2(num_layers);
    localparam int prom_aw = 2 + 2 * num_layers;

    logic [win_w-1:0]   prom_mem [2**prom_aw];
    logic [prom_aw-1:0] prom_addr;
    logic [win_w-1:0]   winner;
    logic [win_w+7:0]   pal_addr;
    logic [win_w-1:0]   prom_q;
    region_e            rd_region;
    logic [15:0]        rdata_gr;
    logic [7:0]         rdata_b;
    logic               we_gr;
    logic               we_b;
    logic [2:0]         lhbl_sr;
    logic [2:0]         lvbl_sr;

    // prisel on top, then opaque and priority bit per layer, layer 0 highest
    always_comb begin
        prom_addr = '0;
        prom_addr[2*num_layers +: 2] = prisel;
        for (int i = 0; i < num_layers; i++)
            prom_addr[2*(num_layers-1-i) +: 2] = {layers[i].opaque, layers[i].pxl[7]};
    end

    // asynchronous PROM read
    assign winner = prom_mem[prom_addr];

    // tick 2, palette address is winner index then winner pixel
    always_ff @(posedge clk) begin
        if (pxl_cen)
            pal_addr <= {winner, layers[winner].pxl};
    end

    // host side of the PROM
    always_ff @(posedge clk) begin
        if (mem.stb && mem.we && mem.region == prom)
            prom_mem[mem.addr] <= mem.wdata[win_w-1:0];
        if (mem.stb) begin
            prom_q    <= prom_mem[mem.addr];
            rd_region <= mem.region;
        end
    end

    assign we_gr = mem.stb && mem.we && (mem.region == palette_gr);
    assign we_b  = mem.stb && mem.we && (mem.region == palette_b);

    // tick 3 is the palette video read register
    palette_ram u_palette (
        .clk           (clk),
        .host_addr     (mem.addr),
        .host_we_gr    (we_gr),
        .host_we_b     (we_b),
        .host_wdata    (mem.wdata),
        .host_rdata_gr (rdata_gr),
        .host_rdata_b  (rdata_b),
        .vid_addr      (pal_addr),
        .vid_en        (pxl_cen),
        .vid_rgb       (rgb)
    );

    // read-back, narrow regions zero-extended
    always_comb begin
        case (rd_region)
            palette_gr: mem.rdata = rdata_gr;
            palette_b:  mem.rdata = {8'h00, rdata_b};
            prom:       mem.rdata = {{(16-win_w){1'b0}}, prom_q};
            default:    mem.rdata = '0;
        endcase
    end

    // blanking follows the three pixel ticks
    always_ff @(posedge clk) begin
        if (reset) begin
            lhbl_sr <= '0;
            lvbl_sr <= '0;
        end else if (pxl_cen) begin
            lhbl_sr <= {lhbl_sr[1:0], lhbl};
            lvbl_sr <= {lvbl_sr[1:0], lvbl};
        end
    end

    assign lhbl_dly = lhbl_sr[2];
    assign lvbl_dly = lvbl_sr[2];

    // register block stays in the bridge
    no_regs_strobe: assert property (@(posedge clk) disable iff (reset)
        mem.stb |-> mem.region != regs);

endmodule

// File: colmix_top.sv
// colour mixer top level, bridge, four layer stages and mixer behind plain ports
module colmix_top import colmix_pkg::*; #(
    parameter int host_addr_w = 12
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   pxl_cen,
    input  logic                   lhbl,
    input  logic                   lvbl,
    input  logic [7:0]             ba0_pxl,
    input  logic [7:0]             ba1_pxl,
    input  logic [7:0]             ba2_pxl,
    input  logic [7:0]             obj_pxl,
    output logic [7:0]             red,
    output logic [7:0]             green,
    output logic [7:0]             blue,
    output logic                   lhbl_dly,
    output logic                   lvbl_dly,
    input  logic                   host_req,
    output logic                   host_ack,
    input  logic                   host_we,
    input  logic [host_addr_w-1:0] host_addr,
    input  logic [15:0]            host_wdata,
    output logic [15:0]            host_rdata
);

    pixel_t     pxl_in    [num_layers];
    layer_cfg_t layer_cfg [num_layers];
    layer_out_t layers    [num_layers];
    logic [1:0] prisel;
    rgb_t       rgb;

    mem_if bus ();

    // layer order sets the PROM address bits
    assign pxl_in[0] = ba0_pxl;
    assign pxl_in[1] = ba1_pxl;
    assign pxl_in[2] = ba2_pxl;
    assign pxl_in[3] = obj_pxl;

    host_bridge #(
        .host_addr_w (host_addr_w)
    ) u_bridge (
        .clk       (clk),
        .reset     (reset),
        .req       (host_req),
        .we        (host_we),
        .addr      (host_addr),
        .wdata     (host_wdata),
        .ack       (host_ack),
        .rdata     (host_rdata),
        .layer_cfg (layer_cfg),
        .prisel    (prisel),
        .mem       (bus.manager)
    );

    for (genvar i = 0; i < num_layers; i++) begin : g_layer
        layer_unit u_layer (
            .clk     (clk),
            .reset   (reset),
            .pxl_cen (pxl_cen),
            .pxl     (pxl_in[i]),
            .cfg     (layer_cfg[i]),
            .out     (layers[i])
        );
    end

    priority_mixer u_mixer (
        .clk      (clk),
        .reset    (reset),
        .pxl_cen  (pxl_cen),
        .layers   (layers),
        .prisel   (prisel),
        .lhbl     (lhbl),
        .lvbl     (lvbl),
        .rgb      (rgb),
        .lhbl_dly (lhbl_dly),
        .lvbl_dly (lvbl_dly),
        .mem      (bus.subordinate)
    );

    assign red   = rgb[23:16];
    assign green = rgb[15:8];
    assign blue  = rgb[7:0];

endmodule

// File: tb_colmix.sv
// self-checking testbench for colmix_top, replays the host and pixel records of colmix_tests.txt
module tb_colmix;
    timeunit 1ns;
    timeprecision 100ps;

    // one pixel vector waiting for its colour
    typedef struct packed {
        logic [31:0] tick;
        logic [31:0] line;
        logic [7:0]  red;
        logic [7:0]  green;
        logic [7:0]  blue;
        logic        hbl;
        logic        vbl;
    } expect_t;

    logic        clk;
    logic        reset;
    logic        pxl_cen;
    logic        lhbl;
    logic        lvbl;
    logic [7:0]  ba0_pxl;
    logic [7:0]  ba1_pxl;
    logic [7:0]  ba2_pxl;
    logic [7:0]  obj_pxl;
    logic [7:0]  red;
    logic [7:0]  green;
    logic [7:0]  blue;
    logic        lhbl_dly;
    logic        lvbl_dly;
    logic        host_req;
    logic        host_ack;
    logic        host_we;
    logic [11:0] host_addr;
    logic [15:0] host_wdata;
    logic [15:0] host_rdata;

    expect_t     pending [$];
    logic [31:0] tick_count;
    int          tests;
    int          failed;
    bit          aborted;

    colmix_top #(
        .host_addr_w (12)
    ) u_colmix_top (
        .clk        (clk),
        .reset      (reset),
        .pxl_cen    (pxl_cen),
        .lhbl       (lhbl),
        .lvbl       (lvbl),
        .ba0_pxl    (ba0_pxl),
        .ba1_pxl    (ba1_pxl),
        .ba2_pxl    (ba2_pxl),
        .obj_pxl    (obj_pxl),
        .red        (red),
        .green      (green),
        .blue       (blue),
        .lhbl_dly   (lhbl_dly),
        .lvbl_dly   (lvbl_dly),
        .host_req   (host_req),
        .host_ack   (host_ack),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata)
    );

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // returns 1 on a wrong value
    function automatic int check_value(input string name, input logic [15:0] got,
                                       input logic [15:0] exp);
        int bad;
        bad = 0;
        assert (got === exp) else begin
            $display("Mismatch at %0t ns: %s expected 0x%0h got 0x%0h", $time, name, exp, got);
            bad = 1;
        end
        return bad;
    endfunction

    function automatic void finish_test(input int line_no, input string what, input int bad);
        tests++;
        if (bad != 0) begin
            failed++;
            $display("test %0d: %s at line %0d FAILED", tests, what, line_no);
        end else begin
            $display("test %0d: %s at line %0d ok", tests, what, line_no);
        end
    endfunction

    // four-phase access, all sampling on the falling edge
    task automatic host_access(input logic wr, input logic [11:0] addr, input logic [15:0] wdata,
                               output logic [15:0] rdata, output int bad);
        int waited;
        bad = 0;
        rdata = '0;
        @(negedge clk);
        // ack may not be up before a request
        assert (host_ack == 1'b0) else begin
            $display("%0t ns: ack was high with no request pending", $time);
            bad++;
        end
        host_req   = 1'b1;
        host_we    = wr;
        host_addr  = addr;
        host_wdata = wdata;
        waited = 0;
        while (!host_ack && waited < 200) begin
            @(negedge clk);
            waited++;
        end
        if (!host_ack) begin
            $display("%0t ns: host port gave no ack within 200 cycles", $time);
            bad++;
            aborted = 1'b1;
        end else begin
            rdata = host_rdata;
            // held req, ack has to stay up
            repeat (2) begin
                @(negedge clk);
                assert (host_ack) else begin
                    $display("%0t ns: ack dropped while req was still held", $time);
                    bad++;
                end
            end
        end
        host_req = 1'b0;
        waited = 0;
        while (host_ack && waited < 200) begin
            @(negedge clk);
            waited++;
        end
        if (host_ack) begin
            $display("%0t ns: ack stayed high 200 cycles after req fell", $time);
            bad++;
            aborted = 1'b1;
        end
    endtask

    // one pxl_cen tick, enable high for a single cycle
    task automatic pixel_tick(input logic [7:0] p0, input logic [7:0] p1, input logic [7:0] p2,
                              input logic [7:0] p3, input logic hb, input logic vb);
        @(negedge clk);
        ba0_pxl = p0;
        ba1_pxl = p1;
        ba2_pxl = p2;
        obj_pxl = p3;
        lhbl    = hb;
        lvbl    = vb;
        pxl_cen = 1'b1;
        @(negedge clk);
        pxl_cen = 1'b0;
        tick_count++;
    endtask

    // colour is out after the third tick, counting the sampling one
    task automatic check_due();
        expect_t e;
        int      bad;
        while (pending.size() > 0 && tick_count >= pending[0].tick + 2) begin
            e = pending.pop_front();
            bad = 0;
            bad += check_value("red", {8'h00, red}, {8'h00, e.red});
            bad += check_value("green", {8'h00, green}, {8'h00, e.green});
            bad += check_value("blue", {8'h00, blue}, {8'h00, e.blue});
            bad += check_value("lhbl_dly", {15'd0, lhbl_dly}, {15'd0, e.hbl});
            bad += check_value("lvbl_dly", {15'd0, lvbl_dly}, {15'd0, e.vbl});
            finish_test(int'(e.line), "pixel", bad);
        end
    endtask

    // drain in-flight vectors before any host access
    task automatic flush_pipeline();
        while (pending.size() > 0) begin
            pixel_tick(8'h00, 8'h00, 8'h00, 8'h00, 1'b0, 1'b0);
            check_due();
        end
    endtask

    initial begin
        int          fd;
        int          n;
        int          line_no;
        int          bad;
        string       line;
        byte         kind;
        logic [15:0] a;
        logic [15:0] d;
        logic [15:0] got;
        logic [7:0]  p0;
        logic [7:0]  p1;
        logic [7:0]  p2;
        logic [7:0]  p3;
        logic [7:0]  er;
        logic [7:0]  eg;
        logic [7:0]  eb;
        logic        hb;
        logic        vb;
        logic        eh;
        logic        ev;
        expect_t     e;

        reset      = 1'b1;
        pxl_cen    = 1'b0;
        lhbl       = 1'b0;
        lvbl       = 1'b0;
        ba0_pxl    = '0;
        ba1_pxl    = '0;
        ba2_pxl    = '0;
        obj_pxl    = '0;
        host_req   = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        tick_count = '0;
        tests      = 0;
        failed     = 0;
        aborted    = 1'b0;
        repeat (5) @(negedge clk);
        reset = 1'b0;

        // ack and blanking come out of reset low
        @(negedge clk);
        bad = check_value("host_ack", {15'd0, host_ack}, 16'h0000);
        bad += check_value("lhbl_dly", {15'd0, lhbl_dly}, 16'h0000);
        bad += check_value("lvbl_dly", {15'd0, lvbl_dly}, 16'h0000);
        finish_test(0, "reset state", bad);

        fd = $fopen("colmix_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open colmix_tests.txt for reading");
            aborted = 1'b1;
        end
        line_no = 0;
        while (fd != 0 && !aborted && !$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            line_no++;
            if (n <= 0 || line.len() < 2)
                continue;
            kind = line.getc(0);
            case (kind)
                "W": begin
                    flush_pipeline();
                    n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, d);
                    host_access(1'b1, a[11:0], d, got, bad);
                    finish_test(line_no, "host write", bad);
                end
                "R": begin
                    flush_pipeline();
                    n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, d);
                    host_access(1'b0, a[11:0], 16'h0000, got, bad);
                    bad += check_value("host_rdata", got, d);
                    finish_test(line_no, "host read", bad);
                end
                "P": begin
                    n = $sscanf(line.substr(1, line.len() - 1),
                                "%h %h %h %h %h %h %h %h %h %h %h",
                                p0, p1, p2, p3, hb, vb, er, eg, eb, eh, ev);
                    pixel_tick(p0, p1, p2, p3, hb, vb);
                    e.tick  = tick_count;
                    e.line  = line_no;
                    e.red   = er;
                    e.green = eg;
                    e.blue  = eb;
                    e.hbl   = eh;
                    e.vbl   = ev;
                    pending.push_back(e);
                    check_due();
                end
                "#": begin
                end
                default: begin
                    $display("line %0d of colmix_tests.txt has an unknown record type", line_no);
                    aborted = 1'b1;
                end
            endcase
        end
        flush_pipeline();
        if (fd != 0)
            $fclose(fd);

        $display("tests %0d, passed %0d, failed %0d", tests, tests - failed, failed);
        if (failed == 0 && !aborted && tests > 1) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: colmix_tests.txt
# W addr data | R addr expected | P ba0 ba1 ba2 obj lhbl lvbl red green blue lhbl_dly lvbl_dly
# all values hex; prom at 0x800 + {prisel, L0 op/pri, L1, L2, obj}, configs at 0xC00, prisel 0xC04
W 000 3322
W 400 FF44
W 800 0000
R 000 3322
R 400 0044
R 800 0000
# all layers disabled after reset, palette entry 0 shows
P 8F 5A 33 FF 1 1 22 33 44 1 1
W C03 FF15
R C03 0015
# masking, layers 0 and 1 enabled
W 8A0 0000
W 820 0001
W 005 A1B2
W 405 00C3
W 103 D4E5
W 503 00F6
W C00 001F
W C01 001F
P 05 03 00 00 1 1 B2 A1 C3 1 1
W C00 0018
P 05 03 00 00 1 1 E5 D4 F6 1 1
# priority bits and prisel
W C00 001F
W 8E0 0000
W 9E0 0001
W 9B0 0001
W 085 1020
W 485 0030
W 183 4050
W 583 0060
P 85 03 00 00 1 1 20 10 30 1 1
W C04 0001
R C04 0001
R 9E0 0001
# back-to-back vectors with blanking changes
P 85 03 00 00 1 1 E5 D4 F6 1 1
P 05 83 00 00 1 1 50 40 60 1 1
P 85 03 00 00 0 1 E5 D4 F6 0 1
P 05 83 00 00 1 0 50 40 60 1 0
P 85 03 00 00 0 0 E5 D4 F6 0 0

// File: flist.f
colmix_pkg.sv
colmix_ifs.sv
palette_ram.sv
layer_unit.sv
host_bridge.sv
priority_mixer.sv
colmix_top.sv
tb_colmix.sv

// File: Makefile
# Verilator build and run of the colour mixer testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build tb_colmix with Verilator, run it, check $(LOG) for a pass"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_colmix -f flist.f -o tb_colmix
	./obj_dir/tb_colmix | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
